// File: design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define XLEN 32
`define REG_AW 5
`define NREG 32

// compaction logic assumes exactly 3
`define WIN_DEPTH 3

// instruction fields
`define OPC_MSB 31
`define OPC_LSB 26
`define DD_LSB 21
`define DS_LSB 16
`define DT_LSB 11

`define OPC_ALU 6'b000000
`define OPC_ADDI 6'b001000

// function code in bits 2:0 of the alu group
`define FN_ADD 3'b000
`define FN_SUB 3'b001
`define FN_AND 3'b010
`define FN_OR 3'b011

`endif

// File: design/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_OR = 2'd3
	} alu_op_t;

	// one decoded instruction as it waits in the window
	typedef struct packed {
		logic valid;
		alu_op_t op;
		logic [`REG_AW-1:0] dd;
		logic [`REG_AW-1:0] ds;
		logic [`REG_AW-1:0] dt;
		// register-register form
		logic use_dt;
		// second operand from imm
		logic use_imm;
		// already sign-extended
		logic [`XLEN-1:0] imm;
	} issue_entry_t;

endpackage

// File: design/inst_decoder.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module inst_decoder (
	input logic clk,
	input logic rstn,
	input logic i_hold,
	input logic [`XLEN-1:0] i_instr0,
	input logic [`XLEN-1:0] i_instr1,
	input logic i_valid0,
	input logic i_valid1,
	output cpu_pkg::issue_entry_t o_dec0,
	output cpu_pkg::issue_entry_t o_dec1
);

	cpu_pkg::issue_entry_t dec0_nxt;
	cpu_pkg::issue_entry_t dec1_nxt;

	function automatic cpu_pkg::issue_entry_t decode(input logic [`XLEN-1:0] instr,
			input logic vld);
		cpu_pkg::issue_entry_t e;
		logic [`OPC_MSB-`OPC_LSB:0] opc;
		logic ok;
		e = '0;
		ok = 1'b0;
		opc = instr[`OPC_MSB:`OPC_LSB];
		e.dd = instr[`DD_LSB +: `REG_AW];
		e.ds = instr[`DS_LSB +: `REG_AW];
		e.dt = instr[`DT_LSB +: `REG_AW];
		e.imm = {{(`XLEN-16){instr[15]}}, instr[15:0]};
		if (opc == `OPC_ADDI) begin
			ok = 1'b1;
			e.op = cpu_pkg::ALU_ADD;
			e.use_imm = 1'b1;
		end else if (opc == `OPC_ALU) begin
			e.use_dt = 1'b1;
			ok = 1'b1;
			case (instr[2:0])
				`FN_ADD: e.op = cpu_pkg::ALU_ADD;
				`FN_SUB: e.op = cpu_pkg::ALU_SUB;
				`FN_AND: e.op = cpu_pkg::ALU_AND;
				`FN_OR: e.op = cpu_pkg::ALU_OR;
				default: ok = 1'b0;
			endcase
		end
		// r0 is never written, so such an op has no effect at all
		if (!vld || !ok || e.dd == '0) begin
			e = '0;
		end else begin
			e.valid = 1'b1;
		end
		return e;
	endfunction

	assign dec0_nxt = decode(i_instr0, i_valid0);
	assign dec1_nxt = decode(i_instr1, i_valid1);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_dec0 <= '0;
			o_dec1 <= '0;
		end else if (!i_hold) begin
			o_dec0 <= dec0_nxt;
			o_dec1 <= dec1_nxt;
		end
	end

endmodule

// File: design/issue_window.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module issue_window #(
	parameter type T_ENTRY = cpu_pkg::issue_entry_t
) (
	input logic clk,
	input logic rstn,
	input T_ENTRY i_dec0,
	input T_ENTRY i_dec1,
	input logic [`WIN_DEPTH-1:0] i_issued,
	output T_ENTRY o_ent0,
	output T_ENTRY o_ent1,
	output T_ENTRY o_ent2,
	output logic o_busy
);

	// slot 0 is the oldest
	T_ENTRY ent [`WIN_DEPTH];
	T_ENTRY nxt [`WIN_DEPTH];
	logic [`WIN_DEPTH-1:0] exist;
	logic [1:0] fill;

	// still waiting after this cycle's issue
	always_comb begin
		for (int k = 0; k < `WIN_DEPTH; k++) begin
			exist[k] = ent[k].valid && !i_issued[k];
		end
	end

	// two left means no room for a full pair
	assign o_busy = (exist[0] && exist[1]) || (exist[1] && exist[2]) ||
		(exist[0] && exist[2]);

	// shift survivors down, then append the decoded pair behind them
	always_comb begin
		fill = 2'd0;
		for (int k = 0; k < `WIN_DEPTH; k++) begin
			nxt[k] = '0;
		end
		for (int k = 0; k < `WIN_DEPTH; k++) begin
			if (exist[k]) begin
				nxt[fill] = ent[k];
				fill = fill + 2'd1;
			end
		end
		if (!o_busy) begin
			if (i_dec0.valid) begin
				nxt[fill] = i_dec0;
				fill = fill + 2'd1;
			end
			// at most one survivor here, so slot 2 is always free
			if (i_dec1.valid) begin
				nxt[fill] = i_dec1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int k = 0; k < `WIN_DEPTH; k++) begin
				ent[k] <= '0;
			end
		end else begin
			for (int k = 0; k < `WIN_DEPTH; k++) begin
				ent[k] <= nxt[k];
			end
		end
	end

	assign o_ent0 = ent[0];
	assign o_ent1 = ent[1];
	assign o_ent2 = ent[2];

endmodule

// File: design/issue_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module issue_unit (
	input logic clk,
	input logic rstn,
	input cpu_pkg::issue_entry_t i_ent0,
	input cpu_pkg::issue_entry_t i_ent1,
	input cpu_pkg::issue_entry_t i_ent2,
	output logic [`WIN_DEPTH-1:0] o_issued,
	output logic o_wb_valid,
	output logic [`REG_AW-1:0] o_wb_addr,
	output logic [`XLEN-1:0] o_wb_data
);

	cpu_pkg::issue_entry_t ent [`WIN_DEPTH];
	cpu_pkg::issue_entry_t sel;
	logic [`NREG-1:0] src_mask [`WIN_DEPTH];
	logic [`NREG-1:0] dd_mask [`WIN_DEPTH];
	logic [`NREG-1:0] older_src;
	logic [`NREG-1:0] older_dd;
	logic [`NREG-1:0] sb;
	logic [`NREG-1:0] sb_clr;
	logic [`NREG-1:0] sb_set;
	logic [`NREG-1:0] sb_eff;
	logic issue_any;

	logic [`XLEN-1:0] regfile [`NREG];
	logic [`XLEN-1:0] rd_a;
	logic [`XLEN-1:0] rd_b;

	// operand latch
	logic ex_valid;
	cpu_pkg::alu_op_t ex_op;
	logic [`REG_AW-1:0] ex_dd;
	logic [`XLEN-1:0] ex_a;
	logic [`XLEN-1:0] ex_b;
	logic [`XLEN-1:0] alu_res;

	// result register
	logic wb_valid;
	logic [`REG_AW-1:0] wb_addr;
	logic [`XLEN-1:0] wb_data;

	assign ent[0] = i_ent0;
	assign ent[1] = i_ent1;
	assign ent[2] = i_ent2;

	always_comb begin
		for (int k = 0; k < `WIN_DEPTH; k++) begin
			src_mask[k] = '0;
			dd_mask[k] = '0;
			if (ent[k].valid) begin
				src_mask[k] = `NREG'(1) << ent[k].ds;
				if (ent[k].use_dt) begin
					src_mask[k] = src_mask[k] | (`NREG'(1) << ent[k].dt);
				end
				dd_mask[k] = `NREG'(1) << ent[k].dd;
			end
		end
	end

	// the bit retiring at this edge no longer blocks
	assign sb_clr = wb_valid ? (`NREG'(1) << wb_addr) : '0;
	assign sb_eff = sb & ~sb_clr;

	// oldest entry free of RAW, WAR and WAW hazards wins
	always_comb begin
		older_src = '0;
		older_dd = '0;
		o_issued = '0;
		for (int k = 0; k < `WIN_DEPTH; k++) begin
			if (ent[k].valid && o_issued == '0 &&
					((sb_eff | older_dd) & (src_mask[k] | dd_mask[k])) == '0 &&
					(older_src & dd_mask[k]) == '0) begin
				o_issued[k] = 1'b1;
			end
			older_src = older_src | src_mask[k];
			older_dd = older_dd | dd_mask[k];
		end
	end

	always_comb begin
		sel = '0;
		for (int k = 0; k < `WIN_DEPTH; k++) begin
			if (o_issued[k]) begin
				sel = ent[k];
			end
		end
	end

	assign issue_any = |o_issued;
	assign sb_set = issue_any ? (`NREG'(1) << sel.dd) : '0;

	// write-through read, r0 reads zero
	assign rd_a = (sel.ds == '0) ? '0 :
		(wb_valid && wb_addr == sel.ds) ? wb_data : regfile[sel.ds];
	assign rd_b = (sel.dt == '0) ? '0 :
		(wb_valid && wb_addr == sel.dt) ? wb_data : regfile[sel.dt];

	always_comb begin
		case (ex_op)
			cpu_pkg::ALU_ADD: alu_res = ex_a + ex_b;
			cpu_pkg::ALU_SUB: alu_res = ex_a - ex_b;
			cpu_pkg::ALU_AND: alu_res = ex_a & ex_b;
			default: alu_res = ex_a | ex_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			sb <= '0;
			ex_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			sb <= sb_eff | sb_set;
			ex_valid <= issue_any;
			wb_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_any) begin
			ex_op <= sel.op;
			ex_dd <= sel.dd;
			ex_a <= rd_a;
			ex_b <= sel.use_imm ? sel.imm : rd_b;
		end
		if (ex_valid) begin
			wb_addr <= ex_dd;
			wb_data <= alu_res;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int r = 0; r < `NREG; r++) begin
				regfile[r] <= '0;
			end
		end else if (wb_valid) begin
			regfile[wb_addr] <= wb_data;
		end
	end

	assign o_wb_valid = wb_valid;
	assign o_wb_addr = wb_addr;
	assign o_wb_data = wb_data;

endmodule

// File: design/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core (
	input logic clk,
	input logic rstn,
	input logic [`XLEN-1:0] i_instr0,
	input logic [`XLEN-1:0] i_instr1,
	input logic i_valid0,
	input logic i_valid1,
	output logic o_busy,
	output logic o_wb_valid,
	output logic [`REG_AW-1:0] o_wb_addr,
	output logic [`XLEN-1:0] o_wb_data
);

	cpu_pkg::issue_entry_t dec0;
	cpu_pkg::issue_entry_t dec1;
	cpu_pkg::issue_entry_t ent0;
	cpu_pkg::issue_entry_t ent1;
	cpu_pkg::issue_entry_t ent2;
	logic [`WIN_DEPTH-1:0] issued;

	inst_decoder u_dec (
		.clk(clk),
		.rstn(rstn),
		.i_hold(o_busy),
		.i_instr0(i_instr0),
		.i_instr1(i_instr1),
		.i_valid0(i_valid0),
		.i_valid1(i_valid1),
		.o_dec0(dec0),
		.o_dec1(dec1)
	);

	issue_window #(
		.T_ENTRY(cpu_pkg::issue_entry_t)
	) u_win (
		.clk(clk),
		.rstn(rstn),
		.i_dec0(dec0),
		.i_dec1(dec1),
		.i_issued(issued),
		.o_ent0(ent0),
		.o_ent1(ent1),
		.o_ent2(ent2),
		.o_busy(o_busy)
	);

	issue_unit u_iss (
		.clk(clk),
		.rstn(rstn),
		.i_ent0(ent0),
		.i_ent1(ent1),
		.i_ent2(ent2),
		.o_issued(issued),
		.o_wb_valid(o_wb_valid),
		.o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data)
	);

endmodule

// File: tests/cpu_core_chk.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core_chk (
	input logic clk,
	input logic rstn,
	input logic [`WIN_DEPTH-1:0] i_issued,
	input cpu_pkg::issue_entry_t i_ent0,
	input cpu_pkg::issue_entry_t i_ent1,
	input cpu_pkg::issue_entry_t i_ent2,
	input logic i_busy,
	input logic i_wb_valid,
	input logic [`REG_AW-1:0] i_wb_addr
);

	a_issue_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(i_issued))
		else $error("more than one window slot issued");

	a_issue_valid: assert property (@(posedge clk) disable iff (!rstn)
		(!i_issued[0] || i_ent0.valid) && (!i_issued[1] || i_ent1.valid) &&
		(!i_issued[2] || i_ent2.valid))
		else $error("issue from an empty window slot");

	a_wb_not_r0: assert property (@(posedge clk) disable iff (!rstn)
		i_wb_valid |-> i_wb_addr != '0)
		else $error("write-back to r0");

	// stalled window with no issue keeps its contents
	a_win_hold: assert property (@(posedge clk) disable iff (!rstn)
		(i_busy && i_issued == '0) |=> ($stable(i_ent0) && $stable(i_ent1) && $stable(i_ent2)))
		else $error("window entries changed during a stall");

endmodule

bind cpu_core cpu_core_chk u_chk (
	.clk(clk),
	.rstn(rstn),
	.i_issued(issued),
	.i_ent0(ent0),
	.i_ent1(ent1),
	.i_ent2(ent2),
	.i_busy(o_busy),
	.i_wb_valid(o_wb_valid),
	.i_wb_addr(o_wb_addr)
);

// File: tests/tb_cpu_core.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu_core;

	localparam int TIMEOUT_CYCLES = 3000;

	logic clk;
	logic rstn;
	logic [`XLEN-1:0] i_instr0;
	logic [`XLEN-1:0] i_instr1;
	logic i_valid0;
	logic i_valid1;
	logic o_busy;
	logic o_wb_valid;
	logic [`REG_AW-1:0] o_wb_addr;
	logic [`XLEN-1:0] o_wb_data;

	// register values in program order
	logic [`XLEN-1:0] arch_reg [`NREG];
	// results still owed per destination in program order
	logic [`XLEN-1:0] exp_q [`NREG][$];
	int exp_count = 0;
	int wb_count = 0;
	int cycles = 0;
	integer seed;

	cpu_core dut (
		.clk(clk),
		.rstn(rstn),
		.i_instr0(i_instr0),
		.i_instr1(i_instr1),
		.i_valid0(i_valid0),
		.i_valid1(i_valid1),
		.o_busy(o_busy),
		.o_wb_valid(o_wb_valid),
		.o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input string name, input logic [`XLEN-1:0] expected,
			input logic [`XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			report_failure("timeout, the DUT did not finish all write-backs");
		end
	end

	function automatic logic [`XLEN-1:0] enc_rr(input logic [2:0] fn, input logic [4:0] dd,
			input logic [4:0] ds, input logic [4:0] dt);
		return {`OPC_ALU, dd, ds, dt, 8'h00, fn};
	endfunction

	function automatic logic [`XLEN-1:0] enc_addi(input logic [4:0] dd, input logic [4:0] ds,
			input logic [15:0] imm);
		return {`OPC_ADDI, dd, ds, imm};
	endfunction

	// apply one instruction to the register model
	task automatic model_take(input logic [`XLEN-1:0] instr, input logic vld);
		logic [4:0] dd;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] res;
		logic ok;
		dd = instr[`DD_LSB +: `REG_AW];
		a = arch_reg[instr[`DS_LSB +: `REG_AW]];
		b = arch_reg[instr[`DT_LSB +: `REG_AW]];
		ok = vld;
		res = '0;
		if (instr[`OPC_MSB:`OPC_LSB] == `OPC_ADDI) begin
			res = a + {{16{instr[15]}}, instr[15:0]};
		end else if (instr[`OPC_MSB:`OPC_LSB] == `OPC_ALU) begin
			case (instr[2:0])
				`FN_ADD: res = a + b;
				`FN_SUB: res = a - b;
				`FN_AND: res = a & b;
				`FN_OR: res = a | b;
				default: ok = 1'b0;
			endcase
		end else begin
			ok = 1'b0;
		end
		if (ok && dd != 5'd0) begin
			arch_reg[dd] = res;
			exp_q[dd].push_back(res);
			exp_count++;
		end
	endtask

	task automatic send_pair(input logic [`XLEN-1:0] in0, input logic v0,
			input logic [`XLEN-1:0] in1, input logic v1);
		@(negedge clk);
		i_instr0 = in0;
		i_valid0 = v0;
		i_instr1 = in1;
		i_valid1 = v1;
		// taken at the first rising edge with o_busy low
		while (o_busy) begin
			@(negedge clk);
		end
		model_take(in0, v0);
		model_take(in1, v1);
	endtask

	task automatic drain();
		@(negedge clk);
		i_valid0 = 1'b0;
		i_valid1 = 1'b0;
		while (wb_count != exp_count) begin
			@(posedge clk);
		end
		// a few idle cycles so a stray write-back still shows up
		repeat (4) @(negedge clk);
	endtask

	task automatic take_wb(input logic [4:0] addr, input logic [`XLEN-1:0] data);
		logic [`XLEN-1:0] expected;
		if (addr == 5'd0) begin
			report_failure("write-back to register zero");
		end else if (exp_q[addr].size() == 0) begin
			report_failure($sformatf("unexpected write-back to r%0d", addr));
		end else begin
			expected = exp_q[addr].pop_front();
			wb_count++;
			check_equal($sformatf("o_wb_data r%0d", addr), expected, data);
		end
	endtask

	always @(negedge clk) begin
		if (o_wb_valid === 1'b1) begin
			take_wb(o_wb_addr, o_wb_data);
		end
	end

	task automatic test_reset_idle();
		repeat (6) begin
			@(negedge clk);
			check_equal("o_wb_valid", 0, 32'(o_wb_valid));
			check_equal("o_busy", 0, 32'(o_busy));
		end
	endtask

	task automatic test_independent();
		send_pair(enc_addi(5'd1, 5'd0, 16'h0005), 1'b1, enc_addi(5'd2, 5'd0, 16'hfff0), 1'b1);
		send_pair(enc_addi(5'd3, 5'd0, 16'h1234), 1'b1, enc_addi(5'd4, 5'd0, 16'h8001), 1'b1);
		drain();
		send_pair(enc_rr(`FN_ADD, 5'd5, 5'd1, 5'd2), 1'b1, enc_rr(`FN_SUB, 5'd6, 5'd3, 5'd4), 1'b1);
		send_pair(enc_rr(`FN_AND, 5'd7, 5'd3, 5'd4), 1'b1, enc_rr(`FN_OR, 5'd8, 5'd1, 5'd2), 1'b1);
		drain();
	endtask

	task automatic test_raw_chain();
		send_pair(enc_addi(5'd1, 5'd0, 16'h0007), 1'b1, enc_rr(`FN_ADD, 5'd2, 5'd1, 5'd1), 1'b1);
		send_pair(enc_rr(`FN_SUB, 5'd3, 5'd2, 5'd1), 1'b1, enc_rr(`FN_OR, 5'd4, 5'd3, 5'd2), 1'b1);
		drain();
	endtask

	task automatic test_same_dest();
		send_pair(enc_addi(5'd9, 5'd0, 16'h0001), 1'b1, enc_addi(5'd10, 5'd0, 16'h0002), 1'b1);
		send_pair(enc_rr(`FN_ADD, 5'd9, 5'd9, 5'd10), 1'b1, enc_addi(5'd11, 5'd0, 16'h0003), 1'b1);
		send_pair(enc_addi(5'd9, 5'd9, 16'hfffc), 1'b1, enc_rr(`FN_OR, 5'd12, 5'd11, 5'd10), 1'b1);
		// reads the last value of r9
		send_pair(enc_rr(`FN_ADD, 5'd13, 5'd9, 5'd0), 1'b1, enc_addi(5'd9, 5'd12, 16'h0010), 1'b1);
		drain();
	endtask

	task automatic test_r0_unknown();
		send_pair(enc_addi(5'd0, 5'd0, 16'h0005), 1'b1, 32'hfe80_0001, 1'b1);
		send_pair(enc_rr(3'b111, 5'd20, 5'd1, 5'd2), 1'b1, enc_rr(`FN_ADD, 5'd14, 5'd0, 5'd0), 1'b1);
		send_pair(enc_addi(5'd15, 5'd0, 16'h0042), 1'b1, enc_addi(5'd21, 5'd1, 16'h0001), 1'b0);
		drain();
	endtask

	function automatic logic [4:0] pick_reg(input logic [2:0] f);
		return 5'd1 + {2'b00, f % 3'd7};
	endfunction

	function automatic logic [`XLEN-1:0] rand_instr(input logic [31:0] r);
		case (r[3:1])
			3'd1, 3'd6: return enc_rr(`FN_ADD, pick_reg(r[6:4]), pick_reg(r[9:7]), pick_reg(r[12:10]));
			3'd2, 3'd7: return enc_rr(`FN_SUB, pick_reg(r[6:4]), pick_reg(r[9:7]), pick_reg(r[12:10]));
			3'd3: return enc_rr(`FN_AND, pick_reg(r[6:4]), pick_reg(r[9:7]), pick_reg(r[12:10]));
			3'd4: return enc_rr(`FN_OR, pick_reg(r[6:4]), pick_reg(r[9:7]), pick_reg(r[12:10]));
			default: return enc_addi(pick_reg(r[6:4]), pick_reg(r[9:7]), r[28:13]);
		endcase
	endfunction

	task automatic test_random();
		logic [31:0] ra;
		logic [31:0] rb;
		seed = 8;
		for (int n = 0; n < 200; n++) begin
			ra = $random(seed);
			rb = $random(seed);
			send_pair(rand_instr(ra), ra[0], rand_instr(rb), rb[0]);
		end
		drain();
	endtask

	initial begin
		rstn = 1'b0;
		i_instr0 = '0;
		i_instr1 = '0;
		i_valid0 = 1'b0;
		i_valid1 = 1'b0;
		seed = 8;
		for (int r = 0; r < `NREG; r++) begin
			arch_reg[r] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		test_reset_idle();
		test_independent();
		test_raw_chain();
		test_same_dest();
		test_r0_unknown();
		test_random();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: compile.f
+incdir+design
design/cpu_pkg.sv
design/inst_decoder.sv
design/issue_window.sv
design/issue_unit.sv
design/cpu_core.sv
tests/cpu_core_chk.sv
tests/tb_cpu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu_core
FLIST ?= compile.f
SEED ?= 8
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
